// File: verilog/colour_macros.svh
// widths, default geometry and filter depth for the colour-ball tracker
// the top-level parameters take their defaults from here
`ifndef COLOUR_MACROS_SVH
`define COLOUR_MACROS_SVH

//////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////

// width of one colour channel and of hue, sat and val
`define CHAN_W 8

// width of the x and y raster counters
`define COORD_W 11

// packed {red, green, blue} word on the stream
`define PIXEL_W 24

//////////////////////////////////////////////////
// tracker setup
//////////////////////////////////////////////////

// one tracker per ball colour
`define NUM_COLOURS 4

// matches in a row needed for a filtered hit
// the current pixel counts as one of them
`define FILTER_DEPTH 7

//////////////////////////////////////////////////
// default frame geometry
//////////////////////////////////////////////////

`define IMAGE_W_DEF 640
`define IMAGE_H_DEF 480

// bounds only collect on rows strictly below this one
`define HORIZON_DEF 280

`endif

// File: verilog/colour_pkg.sv
// shared types and per-colour tables for the ball trackers
`include "colour_macros.svh"

package colour_pkg;

	typedef logic [`CHAN_W-1:0] chan_t;
	typedef logic [`COORD_W-1:0] coord_t;

	// tracker index, RED has the highest overlay priority
	typedef enum logic [1:0] {
		RED,
		YELLOW,
		TEAL,
		PINK
	} colour_id_t;

	// decided from the low blue nibble of the sop word
	typedef enum logic {
		PKT_CONTROL,
		PKT_VIDEO
	} packet_kind_t;

	// hue window in half-degrees, wraps when lo > hi
	localparam chan_t hue_lo [`NUM_COLOURS] = '{8'd172, 8'd16, 8'd55, 8'd150};
	localparam chan_t hue_hi [`NUM_COLOURS] = '{8'd6, 8'd30, 8'd85, 8'd170};
	// strict lower limits on sat and val
	localparam chan_t sat_min [`NUM_COLOURS] = '{8'd100, 8'd130, 8'd80, 8'd80};
	localparam chan_t val_min [`NUM_COLOURS] = '{8'd105, 8'd120, 8'd60, 8'd200};

	// colour painted over filtered hits
	localparam logic [`PIXEL_W-1:0] mark_colour [`NUM_COLOURS] =
		'{24'hff1000, 24'hffff00, 24'h008080, 24'hdf55e2};
	// colour of the box edge columns
	localparam logic [`PIXEL_W-1:0] box_colour [`NUM_COLOURS] =
		'{24'hff0000, 24'hffff00, 24'h008080, 24'hffc0cb};

endpackage

// File: verilog/stream_reg.sv
// one-word valid/ready pipeline register for pixel data with sop and eop
`timescale 1ns/10ps
`include "colour_macros.svh"

module stream_reg (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                in_valid,
	output logic                in_ready,
	input  logic [`PIXEL_W-1:0] in_data,
	input  logic                in_sop,
	input  logic                in_eop,
	output logic                out_valid,
	input  logic                out_ready,
	output logic [`PIXEL_W-1:0] out_data,
	output logic                out_sop,
	output logic                out_eop
);

	// room when empty or when the held word leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	// occupancy flag
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// payload loads only on an input transfer
	// held unchanged while stalled
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
			out_sop  <= in_sop;
			out_eop  <= in_eop;
		end
	end

endmodule

// File: verilog/hsv_front.sv
// raster position, packet kind and RGB to HSV conversion for the trackers
`timescale 1ns/10ps
`include "colour_macros.svh"

module hsv_front #(
	parameter int image_w = `IMAGE_W_DEF
) (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic [`PIXEL_W-1:0]      pix_data,
	input  logic                     pix_sop,
	input  logic                     pix_step,
	output colour_pkg::coord_t       x,
	output colour_pkg::coord_t       y,
	output colour_pkg::packet_kind_t kind,
	output colour_pkg::chan_t        hue,
	output colour_pkg::chan_t        sat,
	output colour_pkg::chan_t        val
);
	import colour_pkg::*;

	chan_t r;
	chan_t g;
	chan_t b;
	chan_t max_c;
	chan_t min_c;
	chan_t d;
	chan_t d_div;
	chan_t max_div;
	logic [17:0] hue_num;
	logic [17:0] hue_q;
	logic [15:0] sat_num;
	logic [15:0] sat_q;

	assign {r, g, b} = pix_data;

	//////////////////////////////////////////////////
	// raster counters
	//////////////////////////////////////////////////

	// sop word restarts the frame and picks the packet kind
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x    <= '0;
			y    <= '0;
			kind <= PKT_CONTROL;
		end else if (pix_step) begin
			if (pix_sop) begin
				x    <= '0;
				y    <= '0;
				kind <= (b[3:0] == 4'h0) ? PKT_VIDEO : PKT_CONTROL;
			end else if (x == coord_t'(image_w - 1)) begin
				// end of line
				x <= '0;
				y <= y + coord_t'(1);
			end else begin
				x <= x + coord_t'(1);
			end
		end
	end

	//////////////////////////////////////////////////
	// RGB to HSV
	//////////////////////////////////////////////////

	// ties resolve to red first, then green
	assign max_c = (r >= g && r >= b) ? r : ((g >= b) ? g : b);
	assign min_c = (r <= g && r <= b) ? r : ((g <= b) ? g : b);
	assign d     = max_c - min_c;

	// divisors kept nonzero, results are muxed off when they would be
	assign d_div   = (d == '0) ? chan_t'(1) : d;
	assign max_div = (max_c == '0) ? chan_t'(1) : max_c;

	// hue numerator in degrees times d, always nonnegative
	assign hue_num = (max_c == r) ?
			((g >= b) ? 18'd60 * (g - b) : 18'd360 * d - 18'd60 * (b - g)) :
		(max_c == g) ? 18'd120 * d + 18'd60 * b - 18'd60 * r :
			18'd240 * d + 18'd60 * r - 18'd60 * g;

	assign hue_q = hue_num / {10'd0, d_div};
	// degrees halved to fit 0..180 in one byte
	assign hue   = (d == '0) ? '0 : hue_q[8:1];

	assign sat_num = {8'd0, d} * 16'd255;
	assign sat_q   = sat_num / {8'd0, max_div};
	assign sat     = (max_c == '0) ? '0 : sat_q[7:0];

	assign val = max_c;

endmodule

// File: verilog/colour_tracker.sv
// per-colour threshold match, run filter and horizontal box search
// the box latches at the end of each video frame
`timescale 1ns/10ps
`include "colour_macros.svh"

module colour_tracker #(
	parameter colour_pkg::colour_id_t colour = colour_pkg::RED,
	parameter int image_w     = `IMAGE_W_DEF,
	parameter int horizon_row = `HORIZON_DEF
) (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     pix_step,
	input  logic                     pix_sop,
	input  logic                     pix_eop,
	input  colour_pkg::coord_t       x,
	input  colour_pkg::coord_t       y,
	input  colour_pkg::packet_kind_t kind,
	input  colour_pkg::chan_t        hue,
	input  colour_pkg::chan_t        sat,
	input  colour_pkg::chan_t        val,
	output logic                     hit,
	output colour_pkg::coord_t       box_left,
	output colour_pkg::coord_t       box_right,
	output logic                     box_valid
);
	import colour_pkg::*;

	// empty-box marker for the left bound
	localparam coord_t left_init = coord_t'(image_w - 1);

	chan_t lo;
	chan_t hi;
	logic hue_ok;
	logic match;
	logic grow;
	logic [`FILTER_DEPTH-2:0] hist;
	coord_t min_x;
	coord_t max_x;
	coord_t min_next;
	coord_t max_next;

	//////////////////////////////////////////////////
	// threshold box
	//////////////////////////////////////////////////

	assign lo = hue_lo[colour];
	assign hi = hue_hi[colour];

	// red wraps through zero
	assign hue_ok = (lo <= hi) ? (hue >= lo && hue <= hi) : (hue >= lo || hue <= hi);
	assign match  = hue_ok && (sat > sat_min[colour]) && (val > val_min[colour]);

	// filtered hit needs the whole history set as well
	assign hit = match & (&hist);

	//////////////////////////////////////////////////
	// bound search
	//////////////////////////////////////////////////

	assign grow = hit && (kind == PKT_VIDEO) && (y > coord_t'(horizon_row));

	// next bounds include the current pixel so an eop hit is not lost
	assign min_next = pix_sop ? left_init : ((grow && x < min_x) ? x : min_x);
	assign max_next = pix_sop ? coord_t'(0) : ((grow && x > max_x) ? x : max_x);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			hist  <= '0;
			min_x <= left_init;
			max_x <= '0;
		end else if (pix_step) begin
			// history restarts with every packet
			hist  <= pix_sop ? '0 : {hist[`FILTER_DEPTH-3:0], match};
			min_x <= min_next;
			max_x <= max_next;
		end
	end

	// box holds the last video frame, control packets leave it alone
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			box_left  <= left_init;
			box_right <= '0;
		end else if (pix_step && pix_eop && kind == PKT_VIDEO) begin
			box_left  <= min_next;
			box_right <= max_next;
		end
	end

	assign box_valid = (box_left != left_init) && (box_right != '0);

endmodule

// File: verilog/overlay_mux.sv
// output pixel select: box columns, then filtered hit marks, then grey
`timescale 1ns/10ps
`include "colour_macros.svh"

module overlay_mux (
	input  logic                     mode,
	input  logic [`PIXEL_W-1:0]      pix_data,
	input  logic                     pix_sop,
	input  colour_pkg::packet_kind_t kind,
	input  colour_pkg::coord_t       x,
	input  logic                     hit [`NUM_COLOURS],
	input  colour_pkg::coord_t       box_left [`NUM_COLOURS],
	input  colour_pkg::coord_t       box_right [`NUM_COLOURS],
	input  logic                     box_valid [`NUM_COLOURS],
	output logic [`PIXEL_W-1:0]      out_data
);
	import colour_pkg::*;

	chan_t r;
	chan_t g;
	chan_t b;
	chan_t grey;
	logic box_any;
	logic mark_any;
	logic [`PIXEL_W-1:0] box_pix;
	logic [`PIXEL_W-1:0] mark_pix;

	assign {r, g, b} = pix_data;

	// luma-ish grey, at most 253 so no overflow
	assign grey = (g >> 1) + (r >> 2) + (b >> 2);

	// walk from lowest priority up so RED wins last
	always_comb begin
		box_any  = 1'b0;
		box_pix  = '0;
		mark_any = 1'b0;
		mark_pix = '0;
		for (int i = `NUM_COLOURS - 1; i >= 0; i--) begin
			if (box_valid[i] && (box_left[i] == x || box_right[i] == x)) begin
				box_any = 1'b1;
				box_pix = box_colour[i];
			end
			if (hit[i]) begin
				mark_any = 1'b1;
				mark_pix = mark_colour[i];
			end
		end
	end

	// descriptor words and control packets go through untouched
	always_comb begin
		if (!mode || pix_sop || kind == PKT_CONTROL) begin
			out_data = pix_data;
		end else if (box_any) begin
			out_data = box_pix;
		end else if (mark_any) begin
			out_data = mark_pix;
		end else begin
			out_data = {grey, grey, grey};
		end
	end

endmodule

// File: verilog/colour_tracker_top.sv
// colour-ball tracker top: stream registers, HSV front, trackers and overlay
`timescale 1ns/10ps
`include "colour_macros.svh"

module colour_tracker_top #(
	parameter int image_w     = `IMAGE_W_DEF,
	parameter int image_h     = `IMAGE_H_DEF,
	parameter int horizon_row = `HORIZON_DEF
) (
	input  logic                clk,
	input  logic                reset_n,
	input  logic [`PIXEL_W-1:0] sink_data,
	input  logic                sink_valid,
	input  logic                sink_sop,
	input  logic                sink_eop,
	output logic                sink_ready,
	output logic [`PIXEL_W-1:0] source_data,
	output logic                source_valid,
	output logic                source_sop,
	output logic                source_eop,
	input  logic                source_ready,
	input  logic                mode,
	output colour_pkg::coord_t  box_left [`NUM_COLOURS],
	output colour_pkg::coord_t  box_right [`NUM_COLOURS],
	output logic                box_valid [`NUM_COLOURS]
);
	import colour_pkg::*;

	logic pix_valid;
	logic [`PIXEL_W-1:0] pix_data;
	logic pix_sop;
	logic pix_eop;
	logic out_ready;
	logic pix_step;
	logic [`PIXEL_W-1:0] ovl_data;
	coord_t x;
	coord_t y;
	packet_kind_t kind;
	chan_t hue;
	chan_t sat;
	chan_t val;
	logic hit [`NUM_COLOURS];

	// horizon has to sit inside the frame or no box can ever form
	if (horizon_row >= image_h - 1) begin : g_bad_horizon
		$error("horizon_row must be less than image_h - 1");
	end

	//////////////////////////////////////////////////
	// stream path
	//////////////////////////////////////////////////

	stream_reg in_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(sink_valid), .in_ready(sink_ready),
		.in_data(sink_data), .in_sop(sink_sop), .in_eop(sink_eop),
		.out_valid(pix_valid), .out_ready(out_ready),
		.out_data(pix_data), .out_sop(pix_sop), .out_eop(pix_eop)
	);

	// single advance event for the front, trackers and overlay
	assign pix_step = pix_valid & out_ready;

	stream_reg out_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(pix_valid), .in_ready(out_ready),
		.in_data(ovl_data), .in_sop(pix_sop), .in_eop(pix_eop),
		.out_valid(source_valid), .out_ready(source_ready),
		.out_data(source_data), .out_sop(source_sop), .out_eop(source_eop)
	);

	//////////////////////////////////////////////////
	// analysis and overlay
	//////////////////////////////////////////////////

	hsv_front #(.image_w(image_w)) i_front (
		.clk(clk), .reset_n(reset_n),
		.pix_data(pix_data), .pix_sop(pix_sop), .pix_step(pix_step),
		.x(x), .y(y), .kind(kind), .hue(hue), .sat(sat), .val(val)
	);

	// one tracker per colour id
	for (genvar c = 0; c < `NUM_COLOURS; c++) begin : g_tracker
		colour_tracker #(
			.colour(colour_id_t'(c)),
			.image_w(image_w),
			.horizon_row(horizon_row)
		) i_trk (
			.clk(clk), .reset_n(reset_n),
			.pix_step(pix_step), .pix_sop(pix_sop), .pix_eop(pix_eop),
			.x(x), .y(y), .kind(kind), .hue(hue), .sat(sat), .val(val),
			.hit(hit[c]), .box_left(box_left[c]), .box_right(box_right[c]),
			.box_valid(box_valid[c])
		);
	end

	overlay_mux i_overlay (
		.mode(mode), .pix_data(pix_data), .pix_sop(pix_sop), .kind(kind), .x(x),
		.hit(hit), .box_left(box_left), .box_right(box_right), .box_valid(box_valid),
		.out_data(ovl_data)
	);

endmodule

// File: tests/colour_tracker_props.sv
// stream register handshake properties, bound into every stream_reg
`timescale 1ns/10ps
`include "colour_macros.svh"

module colour_tracker_props (
	input logic                clk,
	input logic                reset_n,
	input logic                out_valid,
	input logic                out_ready,
	input logic [`PIXEL_W-1:0] out_data,
	input logic                out_sop,
	input logic                out_eop
);

	// a stalled word stays offered
	a_valid_hold : assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> out_valid)
		else $error("out_valid dropped before the transfer");

	// payload and flags frozen while stalled
	a_data_stable : assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> $stable(out_data) && $stable(out_sop) && $stable(out_eop))
		else $error("word changed while stalled");

	// register comes out of reset empty
	a_reset_empty : assert property (@(posedge clk)
		!reset_n |=> !out_valid)
		else $error("out_valid high after reset");

endmodule

bind stream_reg colour_tracker_props i_props (
	.clk(clk), .reset_n(reset_n), .out_valid(out_valid), .out_ready(out_ready),
	.out_data(out_data), .out_sop(out_sop), .out_eop(out_eop)
);

// File: tests/tb_colour_tracker.sv
// testbench for the colour-ball tracker top
// directed frames with random stalls checked against a behavioural model
`timescale 1ns/10ps
`include "colour_macros.svh"

module tb_colour_tracker;
	import colour_pkg::*;

	localparam int W = 16;
	localparam int H = 8;
	localparam int HORIZON = 3;
	localparam int NUM_FRAMES = 6;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * (W * H + 1) * 4 + 100;

	logic clk = 1'b0;
	logic reset_n;
	logic [`PIXEL_W-1:0] sink_data;
	logic sink_valid;
	logic sink_sop;
	logic sink_eop;
	logic sink_ready;
	logic [`PIXEL_W-1:0] source_data;
	logic source_valid;
	logic source_sop;
	logic source_eop;
	logic source_ready;
	logic mode;
	coord_t box_left [`NUM_COLOURS];
	coord_t box_right [`NUM_COLOURS];
	logic box_valid [`NUM_COLOURS];

	logic [15:0] lfsr_state = 16'd78;
	int err_count = 0;
	int check_count = 0;
	// frame pixels, expected and collected words as {sop, eop, data}
	logic [23:0] pix_q [$];
	logic [25:0] exp_q [$];
	logic [25:0] got_q [$];
	// model copy of the latched boxes
	int mbox_l [`NUM_COLOURS];
	int mbox_r [`NUM_COLOURS];

	// thresholds and colours as specified for each ball
	int t_hue_lo [4] = '{172, 16, 55, 150};
	int t_hue_hi [4] = '{6, 30, 85, 170};
	int t_sat [4] = '{100, 130, 80, 80};
	int t_val [4] = '{105, 120, 60, 200};
	logic [23:0] t_mark [4] = '{24'hff1000, 24'hffff00, 24'h008080, 24'hdf55e2};
	logic [23:0] t_box [4] = '{24'hff0000, 24'hffff00, 24'h008080, 24'hffc0cb};

	colour_tracker_top #(.image_w(W), .image_h(H), .horizon_row(HORIZON)) i_dut (
		.clk(clk), .reset_n(reset_n),
		.sink_data(sink_data), .sink_valid(sink_valid), .sink_sop(sink_sop),
		.sink_eop(sink_eop), .sink_ready(sink_ready),
		.source_data(source_data), .source_valid(source_valid), .source_sop(source_sop),
		.source_eop(source_eop), .source_ready(source_ready), .mode(mode),
		.box_left(box_left), .box_right(box_right), .box_valid(box_valid)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// random source and helpers
	//////////////////////////////////////////////////

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function logic [7:0] rand8();
		logic [7:0] v;
		for (int i = 0; i < 8; i++) begin
			v[i] = lfsr_bit();
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// hue in half-degrees, sat and val as {h, s, v}
	function automatic logic [23:0] to_hsv(input logic [23:0] p);
		int r;
		int g;
		int b;
		int mx;
		int mn;
		int d;
		int h;
		r = p[23:16];
		g = p[15:8];
		b = p[7:0];
		mx = (r > g) ? r : g;
		mx = (b > mx) ? b : mx;
		mn = (r < g) ? r : g;
		mn = (b < mn) ? b : mn;
		d = mx - mn;
		if (d == 0) h = 0;
		else if (r >= g && r >= b)
			h = (g >= b) ? (60 * (g - b)) / d : (360 * d - 60 * (b - g)) / d;
		else if (g >= b) h = (120 * d + 60 * (b - r)) / d;
		else h = (240 * d + 60 * (r - g)) / d;
		h = h / 2;
		return {8'(h), 8'((mx == 0) ? 0 : d * 255 / mx), 8'(mx)};
	endfunction

	function automatic logic in_box(input int c, input logic [23:0] hsv);
		int h;
		logic hue_ok;
		h = hsv[23:16];
		if (t_hue_lo[c] <= t_hue_hi[c]) hue_ok = (h >= t_hue_lo[c]) && (h <= t_hue_hi[c]);
		else hue_ok = (h >= t_hue_lo[c]) || (h <= t_hue_hi[c]);
		return hue_ok && (hsv[15:8] > t_sat[c]) && (hsv[7:0] > t_val[c]);
	endfunction

	//////////////////////////////////////////////////
	// reference model of one packet
	//////////////////////////////////////////////////

	task automatic model_packet(input logic [23:0] sop_word, input logic mode_val);
		int run [4];
		int lo [4];
		int hi [4];
		int x;
		int y;
		int sel;
		logic video;
		logic [23:0] hsv;
		logic [23:0] o;
		logic [7:0] gr;
		video = (sop_word[3:0] == 4'h0);
		exp_q = {};
		exp_q.push_back({1'b1, 1'b0, sop_word});
		for (int c = 0; c < 4; c++) begin
			run[c] = 0;
			lo[c] = W - 1;
			hi[c] = 0;
		end
		for (int i = 0; i < pix_q.size(); i++) begin
			x = i % W;
			y = i / W;
			hsv = to_hsv(pix_q[i]);
			gr = pix_q[i][15:8] / 2 + pix_q[i][23:16] / 4 + pix_q[i][7:0] / 4;
			o = {gr, gr, gr};
			sel = -1;
			// lowest index wins, so scan downwards
			for (int c = 3; c >= 0; c--) begin
				run[c] = in_box(c, hsv) ? run[c] + 1 : 0;
				if (run[c] >= `FILTER_DEPTH) begin
					o = t_mark[c];
					if (video && y > HORIZON) begin
						lo[c] = (x < lo[c]) ? x : lo[c];
						hi[c] = (x > hi[c]) ? x : hi[c];
					end
				end
				if (mbox_l[c] != W - 1 && mbox_r[c] != 0 && (mbox_l[c] == x || mbox_r[c] == x))
					sel = c;
			end
			if (sel >= 0) o = t_box[sel];
			if (!mode_val || !video) o = pix_q[i];
			exp_q.push_back({1'b0, i == pix_q.size() - 1, o});
		end
		if (video) begin
			for (int c = 0; c < 4; c++) begin
				mbox_l[c] = lo[c];
				mbox_r[c] = hi[c];
			end
		end
	endtask

	//////////////////////////////////////////////////
	// stream drivers
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		source_ready <= lfsr_bit();
	end

	// sampled mid-cycle, the transfer happens at the next rising edge
	always @(negedge clk) begin
		if (reset_n && source_valid && source_ready)
			got_q.push_back({source_sop, source_eop, source_data});
	end

	// sends a packet, checks the words and the exported boxes
	task automatic run_packet(input string name, input logic [23:0] sop_word,
			input logic mode_val);
		int i;
		int n;
		logic acc;
		logic [23:0] w;
		n = pix_q.size();
		model_packet(sop_word, mode_val);
		got_q = {};
		mode <= mode_val;
		i = 0;
		while (i <= n) begin
			w = (i == 0) ? sop_word : pix_q[i - 1];
			sink_data <= w;
			sink_sop <= (i == 0);
			sink_eop <= (i == n);
			sink_valid <= lfsr_bit();
			@(negedge clk);
			acc = sink_valid && sink_ready;
			@(posedge clk);
			if (acc) i++;
		end
		sink_valid <= 1'b0;
		while (got_q.size() < n + 1) @(posedge clk);
		for (int k = 0; k <= n; k++) begin
			check(name, exp_q[k], got_q[k]);
		end
		for (int c = 0; c < 4; c++) begin
			check({name, " box_left"}, mbox_l[c], box_left[c]);
			check({name, " box_right"}, mbox_r[c], box_right[c]);
			check({name, " box_valid"}, mbox_l[c] != W - 1 && mbox_r[c] != 0, box_valid[c]);
		end
	endtask

	// puts a run of pure red pixels on one row
	task automatic red_run(input int row, input int first, input int len);
		for (int k = first; k < first + len; k++) begin
			pix_q[row * W + k] = 24'hff0000;
		end
	endtask

	// near-black background that matches no colour
	task automatic dark_frame();
		pix_q = {};
		for (int k = 0; k < W * H; k++) begin
			pix_q.push_back(24'h202020 + 24'(k % 5));
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_passthrough();
		int e0;
		e0 = err_count;
		pix_q = {};
		for (int k = 0; k < W * H; k++) begin
			pix_q.push_back({rand8(), rand8(), rand8()});
		end
		run_packet("passthrough", 24'h000000, 1'b0);
		$display("test passthrough done, %0d errors", err_count - e0);
	endtask

	task automatic test_grey();
		int e0;
		e0 = err_count;
		pix_q = {};
		// every channel at most 60, so no colour can match
		for (int k = 0; k < W * H; k++) begin
			pix_q.push_back({8'(rand8() % 61), 8'(rand8() % 61), 8'(rand8() % 61)});
		end
		run_packet("grey", 24'h123450, 1'b1);
		$display("test grey done, %0d errors", err_count - e0);
	endtask

	task automatic test_filter();
		int e0;
		e0 = err_count;
		dark_frame();
		red_run(4, 2, 9);
		red_run(6, 4, 6);
		run_packet("filter", 24'h000000, 1'b1);
		// grey of pure red is 0x3f in every channel
		check("filter run start grey", 24'h3f3f3f, got_q[1 + 4 * W + 7][23:0]);
		check("filter mark", 24'hff1000, got_q[1 + 4 * W + 9][23:0]);
		check("filter short run grey", 24'h3f3f3f, got_q[1 + 6 * W + 9][23:0]);
		$display("test filter done, %0d errors", err_count - e0);
	endtask

	task automatic test_bounds();
		int e0;
		e0 = err_count;
		dark_frame();
		red_run(1, 0, 16);
		red_run(3, 0, 16);
		red_run(5, 3, 10);
		run_packet("bounds", 24'h000000, 1'b1);
		check("bounds left", 9, box_left[RED]);
		check("bounds right", 12, box_right[RED]);
		check("bounds valid", 1, box_valid[RED]);
		// same run again so the box stays put for the control packet
		dark_frame();
		red_run(5, 3, 10);
		run_packet("bounds draw", 24'h000000, 1'b1);
		check("bounds draw left", 24'hff0000, got_q[1 + 9][23:0]);
		check("bounds draw right", 24'hff0000, got_q[1 + 2 * W + 12][23:0]);
		$display("test bounds done, %0d errors", err_count - e0);
	endtask

	task automatic test_control();
		int e0;
		e0 = err_count;
		dark_frame();
		red_run(5, 0, 16);
		red_run(6, 0, 16);
		run_packet("control", 24'h000005, 1'b1);
		check("control red unchanged", 24'hff0000, got_q[1 + 5 * W + 10][23:0]);
		check("control keeps left", 9, box_left[RED]);
		check("control keeps right", 12, box_right[RED]);
		check("control keeps valid", 1, box_valid[RED]);
		$display("test control done, %0d errors", err_count - e0);
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		reset_n = 1'b0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		source_ready = 1'b0;
		mode = 1'b0;
		for (int c = 0; c < 4; c++) begin
			mbox_l[c] = W - 1;
			mbox_r[c] = 0;
		end
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		test_passthrough();
		test_grey();
		test_filter();
		test_bounds();
		test_control();
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the DUT stopped moving words before all tests finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: all.f
+incdir+verilog
verilog/colour_pkg.sv
verilog/stream_reg.sv
verilog/hsv_front.sv
verilog/colour_tracker.sv
verilog/overlay_mux.sv
verilog/colour_tracker_top.sv
tests/colour_tracker_props.sv
tests/tb_colour_tracker.sv

// File: run.sh
#!/bin/sh
# build and run the tracker testbench with Verilator, fail on the fail message
verilator --binary --timing --assert -Wno-fatal --top-module tb_colour_tracker \
	-f all.f -Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vtb_colour_tracker > sim.log 2>&1 ;
cat sim.log 2>/dev/null
! grep -q "TESTS FAILED" sim.log &&
grep -q "TESTS PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
